// ==== flist.f ====
hw/axi_demux_pkg.sv
hw/sync_fifo.sv
hw/aw_router.sv
hw/w_steer.sv
hw/b_merge.sv
hw/axi_write_demux.sv
bench/axi_write_demux_asserts.sv
bench/tb_axi_write_demux.sv

// ==== Makefile ====
TOP := tb_axi_write_demux

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f flist.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_axi_write_demux.sv ====
// Testbench with clock, reset, manager, subordinate models and report for the AXI write demux.
module tb_axi_write_demux;
  timeunit 1ns;
  timeprecision 1ps;
  import axi_demux_pkg::*;

  localparam int RANDOM_BURSTS = 40;
  localparam int LIMIT_BURSTS = 8;
  localparam int MAX_BEATS = 4;
  localparam int CYCLES_PER_BEAT = 20;
  localparam int WATCHDOG_CYCLES =
    (RANDOM_BURSTS + LIMIT_BURSTS) * MAX_BEATS * CYCLES_PER_BEAT + 100;

  logic                                  clk = 1'b0;
  logic                                  rst_n = 1'b0;
  logic [SUB_SEL_WIDTH-1:0]              aw_sub_select = '0;
  logic [ADDR_WIDTH-1:0]                 awaddr = '0;
  logic [LEN_WIDTH-1:0]                  awlen = '0;
  logic [SIZE_WIDTH-1:0]                 awsize = '0;
  logic [BURST_WIDTH-1:0]                awburst = '0;
  logic                                  awvalid = 1'b0;
  logic                                  awready;
  logic [DATA_WIDTH-1:0]                 wdata = '0;
  logic [STRB_WIDTH-1:0]                 wstrb = '0;
  logic                                  wlast = 1'b0;
  logic                                  wvalid = 1'b0;
  logic                                  wready;
  logic [RESP_WIDTH-1:0]                 bresp;
  logic                                  bvalid;
  logic                                  bready = 1'b0;
  logic [NUM_SUBS-1:0][ADDR_WIDTH-1:0]   s_awaddr;
  logic [NUM_SUBS-1:0][LEN_WIDTH-1:0]    s_awlen;
  logic [NUM_SUBS-1:0][SIZE_WIDTH-1:0]   s_awsize;
  logic [NUM_SUBS-1:0][BURST_WIDTH-1:0]  s_awburst;
  logic [NUM_SUBS-1:0]                   s_awvalid;
  logic [NUM_SUBS-1:0]                   s_awready;
  logic [NUM_SUBS-1:0][DATA_WIDTH-1:0]   s_wdata;
  logic [NUM_SUBS-1:0][STRB_WIDTH-1:0]   s_wstrb;
  logic [NUM_SUBS-1:0]                   s_wlast;
  logic [NUM_SUBS-1:0]                   s_wvalid;
  logic [NUM_SUBS-1:0]                   s_wready;
  logic [NUM_SUBS-1:0][RESP_WIDTH-1:0]   s_bresp;
  logic [NUM_SUBS-1:0]                   s_bvalid;
  logic [NUM_SUBS-1:0]                   s_bready;
  logic                                  hold_b = 1'b0;
  int unsigned                           b_count = 0;
  int                                    passed_tests = 0;
  int                                    failed_tests = 0;
  int                                    sel_list [$];
  int                                    len_list [$];

  always #50 clk = ~clk;

  axi_write_demux u_dut (.*);

  bind axi_write_demux axi_write_demux_asserts u_asserts (.*);

  always @(posedge clk) begin
    if (rst_n && bvalid && bready) begin
      b_count++;
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      bready = ($urandom_range(0, 3) != 0);
    end
  end

  for (genvar i = 0; i < NUM_SUBS; i++) begin : gen_sub_model
    logic        aw_rdy = 1'b0;
    logic        w_rdy = 1'b0;
    logic        b_vld = 1'b0;
    logic        b_took = 1'b0;
    int unsigned bursts_done = 0;
    int unsigned resp_sent = 0;

    assign s_awready[i] = aw_rdy;
    assign s_wready[i]  = w_rdy;
    assign s_bvalid[i]  = b_vld;
    assign s_bresp[i]   = (i == 0) ? RESP_OKAY : RESP_SLVERR;

    always @(posedge clk) begin
      if (rst_n && s_wvalid[i] && s_wready[i] && s_wlast[i]) begin
        bursts_done++;
      end
      if (rst_n && s_bvalid[i] && s_bready[i]) begin
        resp_sent++;
        b_took = 1'b1;
      end
    end

    // A raised response holds until the demux takes it.
    always @(negedge clk) begin
      if (rst_n) begin
        aw_rdy = ($urandom_range(0, 3) != 0);
        w_rdy  = ($urandom_range(0, 3) != 0);
        if (!b_vld || b_took) begin
          b_vld = !hold_b && (resp_sent < bursts_done) && ($urandom_range(0, 2) == 0);
        end
        b_took = 1'b0;
      end
    end
  end

  task automatic drive_aw(input int n);
    for (int k = 0; k < n; k++) begin
      repeat ($urandom_range(0, 3)) @(negedge clk);
      aw_sub_select = SUB_SEL_WIDTH'(sel_list[k]);
      awaddr        = ADDR_WIDTH'($urandom);
      awlen         = LEN_WIDTH'(len_list[k] - 1);
      awsize        = 3'd2;
      awburst       = 2'b01;
      awvalid       = 1'b1;
      @(posedge clk);
      while (!awready) @(posedge clk);
      @(negedge clk);
      awvalid = 1'b0;
    end
  endtask

  // Shorter gaps than on AW, so data often runs ahead of its address.
  task automatic drive_w(input int n);
    for (int k = 0; k < n; k++) begin
      for (int j = 0; j < len_list[k]; j++) begin
        repeat ($urandom_range(0, 1)) @(negedge clk);
        wdata  = {8'(sel_list[k]), 24'($urandom)};
        wstrb  = '1;
        wlast  = (j == len_list[k] - 1);
        wvalid = 1'b1;
        @(posedge clk);
        while (!wready) @(posedge clk);
        @(negedge clk);
        wvalid = 1'b0;
      end
    end
  endtask

  task automatic run_test(input string name, input int n, input bit hold);
    int unsigned start;
    int          waited;
    start  = b_count;
    waited = 0;
    sel_list.delete();
    len_list.delete();
    for (int k = 0; k < n; k++) begin
      sel_list.push_back($urandom_range(0, NUM_SUBS - 1));
      len_list.push_back($urandom_range(1, MAX_BEATS));
    end
    hold_b = hold;
    fork
      drive_aw(n);
      drive_w(n);
      begin
        repeat (40) @(negedge clk);
        hold_b = 1'b0;
      end
    join
    while (b_count - start < n && waited < n * MAX_BEATS * CYCLES_PER_BEAT) begin
      @(negedge clk);
      waited++;
    end
    if (b_count - start < n) begin
      $display("%s: only %0d of %0d write responses came back before the deadline",
               name, b_count - start, n);
      failed_tests++;
    end else begin
      $display("%s: %0d bursts, all write responses returned", name, n);
      passed_tests++;
    end
  endtask

  initial begin
    void'($urandom(1));
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);
    run_test("random_traffic", RANDOM_BURSTS, 1'b0);
    run_test("outstanding_limit", LIMIT_BURSTS, 1'b1);
    $display("tests passed %0d, failed %0d, assertion failures %0d",
             passed_tests, failed_tests, u_dut.u_asserts.fail_count);
    if (failed_tests == 0 && u_dut.u_asserts.fail_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== bench/axi_write_demux_asserts.sv ====
// Bound concurrent checks and the W beat and B order trackers for the AXI write demux.
module axi_write_demux_asserts (
  input logic                                    clk,
  input logic                                    rst_n,
  input logic [axi_demux_pkg::SUB_SEL_WIDTH-1:0] aw_sub_select,
  input logic [axi_demux_pkg::ADDR_WIDTH-1:0]    awaddr,
  input logic [axi_demux_pkg::LEN_WIDTH-1:0]     awlen,
  input logic [axi_demux_pkg::SIZE_WIDTH-1:0]    awsize,
  input logic [axi_demux_pkg::BURST_WIDTH-1:0]   awburst,
  input logic                                    awvalid,
  input logic                                    awready,
  input logic [axi_demux_pkg::RESP_WIDTH-1:0]    bresp,
  input logic                                    bvalid,
  input logic                                    bready,
  input logic [axi_demux_pkg::NUM_SUBS-1:0][axi_demux_pkg::ADDR_WIDTH-1:0]  s_awaddr,
  input logic [axi_demux_pkg::NUM_SUBS-1:0][axi_demux_pkg::LEN_WIDTH-1:0]   s_awlen,
  input logic [axi_demux_pkg::NUM_SUBS-1:0][axi_demux_pkg::SIZE_WIDTH-1:0]  s_awsize,
  input logic [axi_demux_pkg::NUM_SUBS-1:0][axi_demux_pkg::BURST_WIDTH-1:0] s_awburst,
  input logic [axi_demux_pkg::NUM_SUBS-1:0]      s_awvalid,
  input logic [axi_demux_pkg::NUM_SUBS-1:0][axi_demux_pkg::DATA_WIDTH-1:0]  s_wdata,
  input logic [axi_demux_pkg::NUM_SUBS-1:0][axi_demux_pkg::STRB_WIDTH-1:0]  s_wstrb,
  input logic [axi_demux_pkg::NUM_SUBS-1:0]      s_wlast,
  input logic [axi_demux_pkg::NUM_SUBS-1:0]      s_wvalid,
  input logic [axi_demux_pkg::NUM_SUBS-1:0]      s_wready,
  input logic [axi_demux_pkg::NUM_SUBS-1:0]      s_bready
);
  timeunit 1ns;
  timeprecision 1ps;
  import axi_demux_pkg::*;

  int unsigned              fail_count = 0;
  logic [SUB_SEL_WIDTH-1:0] b_order_q [$];
  int unsigned              outstanding;
  logic                     b_head_valid;
  logic [SUB_SEL_WIDTH-1:0] b_head_sel;
  logic [RESP_WIDTH-1:0]    exp_bresp;
  logic [NUM_SUBS-1:0]      sel_mask;
  logic                     aw_xfer;
  logic                     b_xfer;

  assign aw_xfer   = awvalid && awready;
  assign b_xfer    = bvalid && bready;
  assign sel_mask  = NUM_SUBS'(1) << aw_sub_select;
  // Subordinate 0 always answers OKAY and subordinate 1 SLVERR.
  assign exp_bresp = (b_head_sel == '0) ? RESP_OKAY : RESP_SLVERR;

  // Writes in AW order until their response goes upstream.
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      b_order_q.delete();
      outstanding  <= 0;
      b_head_valid <= 1'b0;
      b_head_sel   <= '0;
    end else begin
      if (b_xfer && b_order_q.size() != 0) begin
        void'(b_order_q.pop_front());
      end
      if (aw_xfer) begin
        b_order_q.push_back(aw_sub_select);
      end
      outstanding  <= b_order_q.size();
      b_head_valid <= (b_order_q.size() != 0);
      if (b_order_q.size() != 0) begin
        b_head_sel <= b_order_q[0];
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
      (!rst_n || $rose(rst_n)) |-> (s_awvalid == '0 && s_wvalid == '0 && !bvalid))
    else begin
      fail_count++;
      $error("A valid was raised during reset or in the first cycle after it");
    end

  a_aw_select: assert property (@(posedge clk) disable iff (!rst_n)
      awvalid |-> (s_awvalid & ~sel_mask) == '0)
    else begin
      fail_count++;
      $error("ERROR %0t s_awvalid = %b, expected %b", $time, $sampled(s_awvalid),
             $sampled(s_awvalid & sel_mask));
    end

  a_b_order: assert property (@(posedge clk) disable iff (!rst_n)
      b_xfer |-> b_head_valid && bresp == exp_bresp)
    else begin
      fail_count++;
      $error("ERROR %0t bresp = %0h, expected %0h (write pending %0b)", $time,
             $sampled(bresp), $sampled(exp_bresp), $sampled(b_head_valid));
    end

  a_b_limit: assert property (@(posedge clk) disable iff (!rst_n)
      outstanding <= MAX_OUTSTANDING)
    else begin
      fail_count++;
      $error("ERROR %0t outstanding = %0d, expected at most %0d", $time,
             $sampled(outstanding), MAX_OUTSTANDING);
    end

  a_b_stable: assert property (@(posedge clk) disable iff (!rst_n)
      bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      fail_count++;
      $error("Upstream response dropped or changed while bready was low");
    end

  for (genvar i = 0; i < NUM_SUBS; i++) begin : gen_sub
    logic [LEN_WIDTH-1:0] len_q [$];
    logic [LEN_WIDTH-1:0] beat;
    logic [LEN_WIDTH-1:0] head_len;
    logic                 head_valid;
    logic                 w_xfer;

    assign w_xfer = s_wvalid[i] && s_wready[i];

    // Burst lengths this subordinate still expects, oldest first.
    always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        len_q.delete();
        beat       <= '0;
        head_len   <= '0;
        head_valid <= 1'b0;
      end else begin
        if (w_xfer && len_q.size() != 0) begin
          if (beat == len_q[0]) begin
            void'(len_q.pop_front());
            beat <= '0;
          end else begin
            beat <= beat + 1'b1;
          end
        end
        if (aw_xfer && aw_sub_select == SUB_SEL_WIDTH'(i)) begin
          len_q.push_back(awlen);
        end
        head_valid <= (len_q.size() != 0);
        if (len_q.size() != 0) begin
          head_len <= len_q[0];
        end
      end
    end

    a_aw_fields: assert property (@(posedge clk) disable iff (!rst_n)
        s_awvalid[i] |-> {s_awaddr[i], s_awlen[i], s_awsize[i], s_awburst[i]} ==
                         {awaddr, awlen, awsize, awburst})
      else begin
        fail_count++;
        $error("ERROR %0t s_aw fields[%0d] = %0h, expected %0h", $time, i,
               $sampled({s_awaddr[i], s_awlen[i], s_awsize[i], s_awburst[i]}),
               $sampled({awaddr, awlen, awsize, awburst}));
      end

    a_w_tag: assert property (@(posedge clk) disable iff (!rst_n)
        s_wvalid[i] |-> s_wdata[i][31:24] == 8'(i))
      else begin
        fail_count++;
        $error("ERROR %0t s_wdata[%0d][31:24] = %0d, expected %0d", $time, i,
               $sampled(s_wdata[i][31:24]), i);
      end

    a_w_last: assert property (@(posedge clk) disable iff (!rst_n)
        w_xfer |-> head_valid && s_wlast[i] == (beat == head_len))
      else begin
        fail_count++;
        $error("ERROR %0t s_wlast[%0d] = %0b, expected %0b (burst pending %0b)", $time, i,
               $sampled(s_wlast[i]), $sampled(beat == head_len), $sampled(head_valid));
      end

    a_w_stable: assert property (@(posedge clk) disable iff (!rst_n)
        s_wvalid[i] && !s_wready[i] |=>
          s_wvalid[i] && $stable({s_wdata[i], s_wstrb[i], s_wlast[i]}))
      else begin
        fail_count++;
        $error("W beat to subordinate %0d dropped or changed while stalled", i);
      end

    // Only the subordinate of the oldest write may see its response taken.
    a_b_ready: assert property (@(posedge clk) disable iff (!rst_n)
        s_bready[i] |-> bready && b_head_valid && b_head_sel == SUB_SEL_WIDTH'(i))
      else begin
        fail_count++;
        $error("ERROR %0t s_bready[%0d] = %0b, expected %0b", $time, i,
               $sampled(s_bready[i]),
               $sampled(bready && b_head_valid && b_head_sel == SUB_SEL_WIDTH'(i)));
      end
  end

endmodule

// ==== hw/axi_write_demux.sv ====
// Top level of the AXI write demux, wiring the AW, W and B stages and the W buffer.
module axi_write_demux (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [axi_demux_pkg::SUB_SEL_WIDTH-1:0] aw_sub_select,
  input  logic [axi_demux_pkg::ADDR_WIDTH-1:0]    awaddr,
  input  logic [axi_demux_pkg::LEN_WIDTH-1:0]     awlen,
  input  logic [axi_demux_pkg::SIZE_WIDTH-1:0]    awsize,
  input  logic [axi_demux_pkg::BURST_WIDTH-1:0]   awburst,
  input  logic                                    awvalid,
  output logic                                    awready,
  input  logic [axi_demux_pkg::DATA_WIDTH-1:0]    wdata,
  input  logic [axi_demux_pkg::STRB_WIDTH-1:0]    wstrb,
  input  logic                                    wlast,
  input  logic                                    wvalid,
  output logic                                    wready,
  output logic [axi_demux_pkg::RESP_WIDTH-1:0]    bresp,
  output logic                                    bvalid,
  input  logic                                    bready,
  output logic [axi_demux_pkg::NUM_SUBS-1:0][axi_demux_pkg::ADDR_WIDTH-1:0]  s_awaddr,
  output logic [axi_demux_pkg::NUM_SUBS-1:0][axi_demux_pkg::LEN_WIDTH-1:0]   s_awlen,
  output logic [axi_demux_pkg::NUM_SUBS-1:0][axi_demux_pkg::SIZE_WIDTH-1:0]  s_awsize,
  output logic [axi_demux_pkg::NUM_SUBS-1:0][axi_demux_pkg::BURST_WIDTH-1:0] s_awburst,
  output logic [axi_demux_pkg::NUM_SUBS-1:0]      s_awvalid,
  input  logic [axi_demux_pkg::NUM_SUBS-1:0]      s_awready,
  output logic [axi_demux_pkg::NUM_SUBS-1:0][axi_demux_pkg::DATA_WIDTH-1:0]  s_wdata,
  output logic [axi_demux_pkg::NUM_SUBS-1:0][axi_demux_pkg::STRB_WIDTH-1:0]  s_wstrb,
  output logic [axi_demux_pkg::NUM_SUBS-1:0]      s_wlast,
  output logic [axi_demux_pkg::NUM_SUBS-1:0]      s_wvalid,
  input  logic [axi_demux_pkg::NUM_SUBS-1:0]      s_wready,
  input  logic [axi_demux_pkg::NUM_SUBS-1:0][axi_demux_pkg::RESP_WIDTH-1:0]  s_bresp,
  input  logic [axi_demux_pkg::NUM_SUBS-1:0]      s_bvalid,
  output logic [axi_demux_pkg::NUM_SUBS-1:0]      s_bready
);
  import axi_demux_pkg::*;

  logic                            w_order_valid;
  logic                            w_order_ready;
  logic [SUB_SEL_WIDTH-1:0]        w_order_sel;
  logic                            b_order_valid;
  logic                            b_order_ready;
  logic [SUB_SEL_WIDTH-1:0]        b_order_sel;
  logic                            buf_valid;
  logic                            buf_ready;
  logic [DATA_WIDTH+STRB_WIDTH:0]  buf_data;

  aw_router u_aw_router (
    .clk, .rst_n,
    .aw_sub_select, .awaddr, .awlen, .awsize, .awburst, .awvalid, .awready,
    .s_awaddr, .s_awlen, .s_awsize, .s_awburst, .s_awvalid, .s_awready,
    .w_order_valid, .w_order_sel, .w_order_ready,
    .b_order_valid, .b_order_sel, .b_order_ready
  );

  // Beats are packed as data, strobe, then last in the low bit.
  sync_fifo #(
    .Depth(WDATA_BUF_DEPTH),
    .Width(DATA_WIDTH + STRB_WIDTH + 1)
  ) u_wdata_buf (
    .clk, .rst_n,
    .push_valid(wvalid),
    .push_ready(wready),
    .push_data ({wdata, wstrb, wlast}),
    .pop_valid (buf_valid),
    .pop_ready (buf_ready),
    .pop_data  (buf_data)
  );

  w_steer u_w_steer (
    .clk, .rst_n,
    .w_order_valid, .w_order_sel, .w_order_ready,
    .buf_valid, .buf_data, .buf_ready,
    .s_wdata, .s_wstrb, .s_wlast, .s_wvalid, .s_wready
  );

  b_merge u_b_merge (
    .clk, .rst_n,
    .b_order_valid, .b_order_sel, .b_order_ready,
    .s_bresp, .s_bvalid, .s_bready,
    .bresp, .bvalid, .bready
  );

endmodule

// ==== hw/b_merge.sv ====
// B merge stage with the response order FIFO that returns responses in AW order.
module b_merge (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    b_order_valid,
  input  logic [axi_demux_pkg::SUB_SEL_WIDTH-1:0] b_order_sel,
  output logic                                    b_order_ready,
  input  logic [axi_demux_pkg::NUM_SUBS-1:0][axi_demux_pkg::RESP_WIDTH-1:0] s_bresp,
  input  logic [axi_demux_pkg::NUM_SUBS-1:0]      s_bvalid,
  output logic [axi_demux_pkg::NUM_SUBS-1:0]      s_bready,
  output logic [axi_demux_pkg::RESP_WIDTH-1:0]    bresp,
  output logic                                    bvalid,
  input  logic                                    bready
);
  import axi_demux_pkg::*;

  logic                     ord_valid;
  logic                     ord_ready;
  logic [SUB_SEL_WIDTH-1:0] ord_sel;

  // Depth of this queue is the outstanding write limit.
  sync_fifo #(
    .Depth(MAX_OUTSTANDING),
    .Width(SUB_SEL_WIDTH)
  ) u_order_fifo (
    .clk,
    .rst_n,
    .push_valid(b_order_valid),
    .push_ready(b_order_ready),
    .push_data (b_order_sel),
    .pop_valid (ord_valid),
    .pop_ready (ord_ready),
    .pop_data  (ord_sel)
  );

  // Only the oldest write may answer.
  assign bvalid = ord_valid && s_bvalid[ord_sel];
  assign bresp  = s_bresp[ord_sel];

  assign ord_ready = bvalid && bready;

  // Responses from other subordinates wait with ready low
  for (genvar i = 0; i < NUM_SUBS; i++) begin : gen_sub
    assign s_bready[i] = ord_valid && (ord_sel == SUB_SEL_WIDTH'(i)) && bready;
  end

endmodule

// ==== hw/w_steer.sv ====
// W steering stage with the runahead order FIFO that routes buffered beats.
module w_steer (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    w_order_valid,
  input  logic [axi_demux_pkg::SUB_SEL_WIDTH-1:0] w_order_sel,
  output logic                                    w_order_ready,
  input  logic                                    buf_valid,
  input  logic [axi_demux_pkg::DATA_WIDTH+axi_demux_pkg::STRB_WIDTH:0] buf_data,
  output logic                                    buf_ready,
  output logic [axi_demux_pkg::NUM_SUBS-1:0][axi_demux_pkg::DATA_WIDTH-1:0] s_wdata,
  output logic [axi_demux_pkg::NUM_SUBS-1:0][axi_demux_pkg::STRB_WIDTH-1:0] s_wstrb,
  output logic [axi_demux_pkg::NUM_SUBS-1:0]      s_wlast,
  output logic [axi_demux_pkg::NUM_SUBS-1:0]      s_wvalid,
  input  logic [axi_demux_pkg::NUM_SUBS-1:0]      s_wready
);
  import axi_demux_pkg::*;

  logic                     ord_valid;
  logic                     ord_ready;
  logic [SUB_SEL_WIDTH-1:0] ord_sel;
  logic [DATA_WIDTH-1:0]    beat_data;
  logic [STRB_WIDTH-1:0]    beat_strb;
  logic                     beat_last;
  logic                     head_ready;

  // Subordinate order of addresses whose data is still to come.
  sync_fifo #(
    .Depth(MAX_AW_RUNAHEAD),
    .Width(SUB_SEL_WIDTH)
  ) u_order_fifo (
    .clk,
    .rst_n,
    .push_valid(w_order_valid),
    .push_ready(w_order_ready),
    .push_data (w_order_sel),
    .pop_valid (ord_valid),
    .pop_ready (ord_ready),
    .pop_data  (ord_sel)
  );

  assign {beat_data, beat_strb, beat_last} = buf_data;

  // A beat moves only once its burst's subordinate is known.
  assign head_ready = ord_valid && s_wready[ord_sel];
  assign buf_ready  = head_ready;

  // Burst done on the last beat, so the next address takes over.
  assign ord_ready = head_ready && buf_valid && beat_last;

  for (genvar i = 0; i < NUM_SUBS; i++) begin : gen_sub
    assign s_wvalid[i] = buf_valid && ord_valid && (ord_sel == SUB_SEL_WIDTH'(i));
    assign s_wdata[i]  = beat_data;
    assign s_wstrb[i]  = beat_strb;
    assign s_wlast[i]  = beat_last;
  end

endmodule

// ==== hw/aw_router.sv ====
// AW routing stage that steers the write address and records its subordinate.
module aw_router (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic [axi_demux_pkg::SUB_SEL_WIDTH-1:0]   aw_sub_select,
  input  logic [axi_demux_pkg::ADDR_WIDTH-1:0]      awaddr,
  input  logic [axi_demux_pkg::LEN_WIDTH-1:0]       awlen,
  input  logic [axi_demux_pkg::SIZE_WIDTH-1:0]      awsize,
  input  logic [axi_demux_pkg::BURST_WIDTH-1:0]     awburst,
  input  logic                                      awvalid,
  output logic                                      awready,
  output logic [axi_demux_pkg::NUM_SUBS-1:0][axi_demux_pkg::ADDR_WIDTH-1:0]  s_awaddr,
  output logic [axi_demux_pkg::NUM_SUBS-1:0][axi_demux_pkg::LEN_WIDTH-1:0]   s_awlen,
  output logic [axi_demux_pkg::NUM_SUBS-1:0][axi_demux_pkg::SIZE_WIDTH-1:0]  s_awsize,
  output logic [axi_demux_pkg::NUM_SUBS-1:0][axi_demux_pkg::BURST_WIDTH-1:0] s_awburst,
  output logic [axi_demux_pkg::NUM_SUBS-1:0]        s_awvalid,
  input  logic [axi_demux_pkg::NUM_SUBS-1:0]        s_awready,
  output logic                                      w_order_valid,
  output logic [axi_demux_pkg::SUB_SEL_WIDTH-1:0]   w_order_sel,
  input  logic                                      w_order_ready,
  output logic                                      b_order_valid,
  output logic [axi_demux_pkg::SUB_SEL_WIDTH-1:0]   b_order_sel,
  input  logic                                      b_order_ready
);
  import axi_demux_pkg::*;

  logic                room_ok;
  logic                aw_xfer;
  logic [NUM_SUBS-1:0] sel_hot;

  // Only this stage pushes the order queues, so room once seen stays until the push.
  assign room_ok = w_order_ready && b_order_ready;

  for (genvar i = 0; i < NUM_SUBS; i++) begin : gen_sub
    assign sel_hot[i]   = (aw_sub_select == SUB_SEL_WIDTH'(i));
    assign s_awvalid[i] = awvalid && sel_hot[i] && room_ok;
    assign s_awaddr[i]  = awaddr;
    assign s_awlen[i]   = awlen;
    assign s_awsize[i]  = awsize;
    assign s_awburst[i] = awburst;
  end

  assign awready = room_ok && s_awready[aw_sub_select];
  assign aw_xfer = awvalid && awready;

  // One entry per accepted address into each order queue.
  assign w_order_valid = aw_xfer;
  assign w_order_sel   = aw_sub_select;
  assign b_order_valid = aw_xfer;
  assign b_order_sel   = aw_sub_select;

endmodule

// ==== hw/sync_fifo.sv ====
// Flop-based synchronous FIFO with valid/ready push and pop ports.
module sync_fifo #(
  parameter int Depth = 2,
  parameter int Width = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push_valid,
  output logic             push_ready,
  input  logic [Width-1:0] push_data,
  output logic             pop_valid,
  input  logic             pop_ready,
  output logic [Width-1:0] pop_data
);

  localparam int PTR_WIDTH = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CNT_WIDTH = $clog2(Depth + 1);
  localparam logic [PTR_WIDTH-1:0] LAST_PTR = PTR_WIDTH'(Depth - 1);
  localparam logic [CNT_WIDTH-1:0] FULL_CNT = CNT_WIDTH'(Depth);

  logic [Width-1:0]     mem [Depth];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [CNT_WIDTH-1:0] count;
  logic                 push;
  logic                 pop;

  assign push_ready = (count != FULL_CNT);
  assign pop_valid  = (count != '0);
  assign push       = push_valid && push_ready;
  assign pop        = pop_valid && pop_ready;

  // Head entry is read straight out of the storage flops.
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap at Depth, which need not be a power of two.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== hw/axi_demux_pkg.sv ====
// Shared widths, depths and AXI response codes for the AXI write demux.
package axi_demux_pkg;

  // Downstream fan-out.
  localparam int NUM_SUBS = 2;
  localparam int SUB_SEL_WIDTH = (NUM_SUBS > 1) ? $clog2(NUM_SUBS) : 1;

  // AXI field widths.
  localparam int ADDR_WIDTH = 12;
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int LEN_WIDTH = 8;
  localparam int SIZE_WIDTH = 3;
  localparam int BURST_WIDTH = 2;
  localparam int RESP_WIDTH = 2;

  // W beats that can be held before their address is accepted.
  localparam int WDATA_BUF_DEPTH = 2;

  // Accepted addresses whose data has not finished.
  localparam int MAX_AW_RUNAHEAD = 4;

  // Accepted addresses still waiting for a write response.
  localparam int MAX_OUTSTANDING = 3;

  // Response codes.
  localparam logic [RESP_WIDTH-1:0] RESP_OKAY = 2'b00;
  localparam logic [RESP_WIDTH-1:0] RESP_SLVERR = 2'b10;

endpackage
